// ==== include/mapper_params.svh ====
// register map and timing constants for the memory mapper
// register indices assume a 32 entry byte-wide register file
// transfer wait is counted in clk cycles, not cpu_cen pulses
`ifndef MAPPER_PARAMS_SVH
`define MAPPER_PARAMS_SVH

`define MAPPER_NREGS        32

`define MAPPER_REG_DATA_HI  0   // transfer data, high byte
`define MAPPER_REG_DATA_LO  1
`define MAPPER_REG_CTRL     2   // bit 0 cpu reset, bit 1 cpu halt
`define MAPPER_REG_IRQ      4
`define MAPPER_IRQ_RESET    7
`define MAPPER_REG_XFER     5   // transfer command
`define MAPPER_REG_RDADDR   7   // three bytes, 7 to 9
`define MAPPER_REG_WRADDR   10  // three bytes, 10 to 12
`define MAPPER_REG_REGION   16  // size at 16+2r, base at 17+2r

`define MAPPER_XFER_CMD_WR  2'b01
`define MAPPER_XFER_CMD_RD  2'b10
`define MAPPER_XFER_WAIT    7

`endif

// ==== design/mapper_bus_pkg.sv ====
// bus side types of the mapper
// addresses are 68000 word addresses, bit 0 is never carried
`default_nettype none

package mapper_bus_pkg;

    // word address, bits 23 to 1
    typedef logic [23:1] addr_t;

    // bus data word
    typedef logic [15:0] word_t;

    // one mapper register
    typedef logic [7:0] byte_t;

    // one-hot, bit r set for region r
    typedef logic [7:0] region_sel_t;

    // cpu function code, 7 means interrupt acknowledge
    typedef logic [2:0] fc_t;

endpackage

`default_nettype wire

// ==== design/mapper_ctrl_pkg.sv ====
// control side types of the mapper
// the transfer FSM encoding is left to the enum default
`default_nettype none

package mapper_ctrl_pkg;

    // index into the 32 entry register file
    typedef logic [4:0] reg_idx_t;

    // size register bits 3..2
    // 0 to 2 give 1 to 3 cpu_cen pulses, 3 hands DTACK to edack_n
    typedef logic [1:0] dtack_cyc_t;

    // MCU single-word transfer
    typedef enum logic [1:0] {
        XFER_IDLE,
        XFER_REQ,      // waiting for bus grant
        XFER_ACCESS,   // MCU owns the bus, strobe low
        XFER_FINISH    // strobe released, read data stored
    } xfer_state_t;

endpackage

`default_nettype wire

// ==== design/mapper_regs.sv ====
// mapper register file, written by the main CPU or by the MCU
// any MCU write locks out CPU writes until rst
// CPU writes only land while no region decodes the bus address
// MCU inputs are taken as already synchronous to clk
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module mapper_regs (
    input  wire                        clk,
    input  wire                        rst,
    input  mapper_bus_pkg::addr_t      cpu_addr,
    input  mapper_bus_pkg::word_t      cpu_dout,
    input  wire [1:0]                  cpu_dsn,
    input  wire                        cpu_rnw,
    input  wire                        cpu_asn,
    input  wire                        region_none,
    input  mapper_ctrl_pkg::reg_idx_t  mcu_addr,
    input  mapper_bus_pkg::byte_t      mcu_dout,
    input  wire                        mcu_wr,
    input  wire                        rd_load,
    input  mapper_bus_pkg::word_t      rd_data,
    input  wire                        xfer_busy,
    output logic [8*`MAPPER_NREGS-1:0] regs_flat,
    output mapper_bus_pkg::byte_t      mcu_din,
    output logic                       xfer_rd,
    output logic                       xfer_wr,
    output mapper_bus_pkg::addr_t      rd_addr,
    output mapper_bus_pkg::addr_t      wr_addr,
    output mapper_bus_pkg::word_t      wr_data,
    output logic                       cpu_rst,
    output logic                       cpu_haltn
);
    import mapper_bus_pkg::*;
    import mapper_ctrl_pkg::*;

    byte_t    mmr [`MAPPER_NREGS];
    logic     mcu_lock;       // set by first MCU write
    logic     wren_cpu;
    logic     wren_cpu_l;
    logic     reg_we;
    reg_idx_t wsel;
    byte_t    wdata;
    logic     xfer_cmd;
    logic     rst_dly;

    // CPU write strobe, low byte lane only
    assign wren_cpu = ~cpu_asn & ~cpu_rnw & ~cpu_dsn[0] & region_none;

    // MCU has priority over a CPU write in the same cycle
    assign wsel   = mcu_wr ? mcu_addr : cpu_addr[5:1];
    assign wdata  = mcu_wr ? mcu_dout : cpu_dout[7:0];
    assign reg_we = mcu_wr | (wren_cpu & ~wren_cpu_l & ~mcu_lock);

    // start pulses, dropped while a transfer is running
    assign xfer_cmd = reg_we & (wsel == `MAPPER_REG_XFER) & ~xfer_busy;
    assign xfer_wr  = xfer_cmd & (wdata[1:0] == `MAPPER_XFER_CMD_WR);
    assign xfer_rd  = xfer_cmd & (wdata[1:0] == `MAPPER_XFER_CMD_RD);

    // lowest index byte is the most significant, top bit dropped
    assign rd_addr = {mmr[`MAPPER_REG_RDADDR][6:0], mmr[`MAPPER_REG_RDADDR+1],
                      mmr[`MAPPER_REG_RDADDR+2]};
    assign wr_addr = {mmr[`MAPPER_REG_WRADDR][6:0], mmr[`MAPPER_REG_WRADDR+1],
                      mmr[`MAPPER_REG_WRADDR+2]};
    assign wr_data = {mmr[`MAPPER_REG_DATA_HI], mmr[`MAPPER_REG_DATA_LO]};

    assign cpu_haltn = ~mmr[`MAPPER_REG_CTRL][1];

    always_comb begin
        for (int i = 0; i < `MAPPER_NREGS; i++) begin
            regs_flat[8*i +: 8] = mmr[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MAPPER_NREGS; i++) begin
                mmr[i] <= (i == `MAPPER_REG_IRQ) ? byte_t'(`MAPPER_IRQ_RESET) : byte_t'(0);
            end
            mcu_lock   <= 1'b0;
            wren_cpu_l <= 1'b0;
        end else begin
            wren_cpu_l <= wren_cpu;
            if (mcu_wr) mcu_lock <= 1'b1;   // sticky until rst
            if (reg_we) mmr[wsel] <= wdata;
            if (rd_load) begin
                // read data from a finished transfer
                mmr[`MAPPER_REG_DATA_HI] <= rd_data[15:8];
                mmr[`MAPPER_REG_DATA_LO] <= rd_data[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        mcu_din <= mmr[mcu_addr];   // readback, one cycle late
    end

    // cpu reset held two extra cycles past rst
    always_ff @(posedge clk) begin
        rst_dly <= mmr[`MAPPER_REG_CTRL][0] | rst;
        cpu_rst <= rst_dly;
    end

endmodule

`default_nettype wire

// ==== design/region_decode.sv ====
// combinational region decode over eight base/size register pairs
// the lowest matching region index wins
// an interrupt acknowledge cycle (fc 7) selects no region
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module region_decode (
    input  wire [8*`MAPPER_NREGS-1:0]   regs_flat,
    input  mapper_bus_pkg::addr_t       addr_out,
    input  mapper_bus_pkg::fc_t         cpu_fc,
    output mapper_bus_pkg::region_sel_t region_active,
    output logic                        region_none,
    output mapper_ctrl_pkg::dtack_cyc_t dtack_cyc
);
    import mapper_bus_pkg::*;

    byte_t       size_reg [8];
    byte_t       base_reg [8];
    region_sel_t match;

    always_comb begin
        for (int r = 0; r < 8; r++) begin
            size_reg[r] = regs_flat[8*(`MAPPER_REG_REGION + 2*r) +: 8];
            base_reg[r] = regs_flat[8*(`MAPPER_REG_REGION + 2*r + 1) +: 8];
        end
    end

    // size bits 1..0 set how many top address bits are compared
    always_comb begin
        match = '0;
        for (int r = 0; r < 8; r++) begin
            case (size_reg[r][1:0])
                2'd0: match[r] = addr_out[23:16] == base_reg[r];        // 64 kB
                2'd1: match[r] = addr_out[23:17] == base_reg[r][7:1];   // 128 kB
                2'd2: match[r] = addr_out[23:19] == base_reg[r][7:3];   // 512 kB
                2'd3: match[r] = addr_out[23:21] == base_reg[r][7:5];   // 2 MB
                default: match[r] = 1'b0;
            endcase
        end
        if (cpu_fc == 3'b111) match = '0;
    end

    // isolate lowest set bit
    assign region_active = match & (~match + region_sel_t'(1));
    assign region_none   = (region_active == '0);

    always_comb begin
        dtack_cyc = '0;
        for (int r = 0; r < 8; r++) begin
            if (region_active[r]) dtack_cyc = size_reg[r][3:2];
        end
    end

endmodule

`default_nettype wire

// ==== design/dtack_gen.sv ====
// CPU DTACK from a count of cpu_cen pulses inside the bus cycle
// wait code 3 hands DTACK over to the external edack_n pin
// cpu_cen is taken as a one clk wide pulse
`timescale 1ns/100ps
`default_nettype none

module dtack_gen (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         cpu_cen,
    input  wire                         cpu_asn,
    input  mapper_ctrl_pkg::dtack_cyc_t dtack_cyc,
    input  wire                         edack_n,
    output logic                        cpu_dtackn
);
    import mapper_ctrl_pkg::*;

    dtack_cyc_t cen_cnt;     // pulses already seen in this cycle
    logic       dtackn_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt  <= '0;
            dtackn_r <= 1'b1;
        end else if (cpu_asn) begin
            // bus cycle over, release on the next edge
            cen_cnt  <= '0;
            dtackn_r <= 1'b1;
        end else if (cpu_cen) begin
            if (cen_cnt == dtack_cyc) begin
                dtackn_r <= 1'b0;   // Nth pulse reached
            end else begin
                cen_cnt <= cen_cnt + 2'd1;
            end
        end
    end

    assign cpu_dtackn = (dtack_cyc == 2'd3) ? edack_n : dtackn_r;

endmodule

`default_nettype wire

// ==== design/mcu_bus_master.sv ====
// MCU single-word bus transfers plus the bus owner mux
// bus_req is a plain level held until bus_grant, no 68000 arbitration
// the MCU drives both byte strobes, so transfers are always full words
// bus_busy from memory stretches the access past the fixed wait
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module mcu_bus_master (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   xfer_rd,
    input  wire                   xfer_wr,
    input  mapper_bus_pkg::addr_t rd_addr,
    input  mapper_bus_pkg::addr_t wr_addr,
    input  mapper_bus_pkg::word_t wr_data,
    input  mapper_bus_pkg::addr_t cpu_addr,
    input  mapper_bus_pkg::word_t cpu_dout,
    input  wire [1:0]             cpu_dsn,
    input  wire                   cpu_rnw,
    input  wire                   cpu_asn,
    input  wire                   bus_grant,
    input  wire                   bus_busy,
    input  mapper_bus_pkg::word_t bus_dout,
    output logic                  bus_req,
    output logic                  bus_mcu,
    output logic                  xfer_busy,
    output logic                  rd_load,
    output mapper_bus_pkg::word_t rd_data,
    output mapper_bus_pkg::addr_t addr_out,
    output mapper_bus_pkg::word_t bus_din,
    output logic [1:0]            bus_dsn,
    output logic                  bus_rnw,
    output logic                  bus_asn
);
    import mapper_ctrl_pkg::*;

    xfer_state_t state;
    logic [2:0]  wait_cnt;
    logic        is_rd;      // current transfer is a read

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= XFER_IDLE;
            wait_cnt <= '0;
            is_rd    <= 1'b0;
        end else begin
            case (state)
                XFER_IDLE: if (xfer_rd || xfer_wr) begin
                    state <= XFER_REQ;
                    is_rd <= xfer_rd;
                end
                XFER_REQ: if (bus_grant) begin
                    state    <= XFER_ACCESS;
                    wait_cnt <= 3'(`MAPPER_XFER_WAIT - 1);
                end
                XFER_ACCESS: begin
                    if (wait_cnt != 0) wait_cnt <= wait_cnt - 3'd1;
                    else if (!bus_busy) state <= XFER_FINISH;
                end
                default: state <= XFER_IDLE;   // finish lasts one cycle
            endcase
        end
    end

    // sample memory data as the access closes
    always_ff @(posedge clk) begin
        if (state == XFER_ACCESS && wait_cnt == 0 && !bus_busy) rd_data <= bus_dout;
    end

    assign bus_req   = (state == XFER_REQ);
    assign bus_mcu   = (state == XFER_ACCESS) || (state == XFER_FINISH);
    assign xfer_busy = (state != XFER_IDLE);
    assign rd_load   = (state == XFER_FINISH) && is_rd;

    // CPU passes straight through unless the MCU owns the bus
    assign addr_out = bus_mcu ? (is_rd ? rd_addr : wr_addr) : cpu_addr;
    assign bus_din  = bus_mcu ? wr_data : cpu_dout;
    assign bus_dsn  = bus_mcu ? 2'b00 : cpu_dsn;
    assign bus_rnw  = bus_mcu ? is_rd : cpu_rnw;
    assign bus_asn  = bus_mcu ? (state != XFER_ACCESS) : cpu_asn;

endmodule

`default_nettype wire

// ==== design/mapper_top.sv ====
// memory mapper top, interconnect only
// cpu_cen comes from outside, no clock divider in here
// interrupts and the sound latch are not modeled
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module mapper_top (
    input  wire                         clk,
    input  wire                         rst,
    input  mapper_bus_pkg::addr_t       cpu_addr,
    input  mapper_bus_pkg::word_t       cpu_dout,
    input  wire [1:0]                   cpu_dsn,
    input  wire                         cpu_rnw,
    input  wire                         cpu_asn,
    input  mapper_bus_pkg::fc_t         cpu_fc,
    input  wire                         cpu_cen,
    input  wire                         edack_n,
    input  mapper_ctrl_pkg::reg_idx_t   mcu_addr,
    input  mapper_bus_pkg::byte_t       mcu_dout,
    input  wire                         mcu_wr,
    input  wire                         bus_grant,
    input  wire                         bus_busy,
    input  mapper_bus_pkg::word_t       bus_dout,
    output mapper_bus_pkg::byte_t       mcu_din,
    output logic                        cpu_rst,
    output logic                        cpu_haltn,
    output logic                        cpu_dtackn,
    output mapper_bus_pkg::region_sel_t region_active,
    output logic                        bus_req,
    output logic                        bus_mcu,
    output mapper_bus_pkg::addr_t       addr_out,
    output mapper_bus_pkg::word_t       bus_din,
    output logic [1:0]                  bus_dsn,
    output logic                        bus_rnw,
    output logic                        bus_asn
);
    import mapper_bus_pkg::*;
    import mapper_ctrl_pkg::*;

    logic [8*`MAPPER_NREGS-1:0] regs_flat;
    logic       region_none;
    dtack_cyc_t dtack_cyc;
    logic       xfer_rd, xfer_wr, xfer_busy, rd_load;
    addr_t      rd_addr, wr_addr;
    word_t      wr_data, rd_data;

    mapper_regs mapper_regs_i (
        .clk, .rst, .cpu_addr, .cpu_dout, .cpu_dsn, .cpu_rnw, .cpu_asn,
        .region_none, .mcu_addr, .mcu_dout, .mcu_wr, .rd_load, .rd_data,
        .xfer_busy, .regs_flat, .mcu_din, .xfer_rd, .xfer_wr, .rd_addr,
        .wr_addr, .wr_data, .cpu_rst, .cpu_haltn
    );

    region_decode region_decode_i (
        .regs_flat, .addr_out, .cpu_fc, .region_active, .region_none, .dtack_cyc
    );

    dtack_gen dtack_gen_i (
        .clk, .rst, .cpu_cen, .cpu_asn, .dtack_cyc, .edack_n, .cpu_dtackn
    );

    mcu_bus_master mcu_bus_master_i (
        .clk, .rst, .xfer_rd, .xfer_wr, .rd_addr, .wr_addr, .wr_data,
        .cpu_addr, .cpu_dout, .cpu_dsn, .cpu_rnw, .cpu_asn, .bus_grant,
        .bus_busy, .bus_dout, .bus_req, .bus_mcu, .xfer_busy, .rd_load,
        .rd_data, .addr_out, .bus_din, .bus_dsn, .bus_rnw, .bus_asn
    );

endmodule

`default_nettype wire

// ==== verif/mapper_properties.sv ====
// concurrent checks on the mapper top, attached with bind
// fail_cnt holds the number of failed assertions
// register layout follows mapper_params.svh
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module mapper_properties (
    input wire                         clk,
    input wire                         rst,
    input mapper_bus_pkg::fc_t         cpu_fc,
    input wire                         cpu_asn,
    input mapper_bus_pkg::region_sel_t region_active,
    input mapper_ctrl_pkg::dtack_cyc_t dtack_cyc,
    input wire                         cpu_dtackn,
    input wire                         cpu_rst,
    input wire                         rd_load,
    input wire                         bus_req,
    input wire                         bus_grant,
    input wire                         bus_mcu,
    input wire                         bus_asn,
    input wire                         bus_rnw,
    input wire [1:0]                   bus_dsn,
    input mapper_bus_pkg::addr_t       addr_out,
    input mapper_bus_pkg::word_t       bus_din,
    input wire [8*`MAPPER_NREGS-1:0]   regs_flat
);
    int fail_cnt = 0;

    // outputs idle right after reset
    a_reset_idle: assert property (@(posedge clk)
        $past(rst) |-> !bus_req && !bus_mcu && bus_asn && cpu_dtackn && !rd_load)
        else begin
            fail_cnt++;
            $error("control outputs not idle after reset");
        end

    a_cpu_rst: assert property (@(posedge clk) $past(rst, 2) |-> cpu_rst)
        else begin
            fail_cnt++;
            $error("cpu_rst not held after reset");
        end

    // interrupt acknowledge never selects a region
    a_fc7: assert property (@(posedge clk) disable iff (rst)
        cpu_fc == 3'd7 |-> region_active == '0)
        else begin
            fail_cnt++;
            $error("region selected in interrupt acknowledge cycle");
        end

    a_dtack_release: assert property (@(posedge clk) disable iff (rst)
        $past(cpu_asn) && dtack_cyc != 2'd3 |-> cpu_dtackn)
        else begin
            fail_cnt++;
            $error("cpu_dtackn low outside a bus cycle");
        end

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        bus_req && !bus_grant |=> bus_req)
        else begin
            fail_cnt++;
            $error("bus_req dropped before grant");
        end

    // MCU write cycle drives the register address and data
    a_wr_bus: assert property (@(posedge clk) disable iff (rst)
        bus_mcu && !bus_asn && !bus_rnw |->
            addr_out == {regs_flat[8*`MAPPER_REG_WRADDR +: 7],
                         regs_flat[8*(`MAPPER_REG_WRADDR+1) +: 8],
                         regs_flat[8*(`MAPPER_REG_WRADDR+2) +: 8]}
            && bus_din == {regs_flat[8*`MAPPER_REG_DATA_HI +: 8],
                           regs_flat[8*`MAPPER_REG_DATA_LO +: 8]}
            && bus_dsn == 2'b00)
        else begin
            fail_cnt++;
            $error("MCU write cycle drives wrong address or data");
        end

endmodule

bind mapper_top mapper_properties mapper_properties_i (
    .clk, .rst, .cpu_fc, .cpu_asn, .region_active, .dtack_cyc, .cpu_dtackn,
    .cpu_rst, .rd_load, .bus_req, .bus_grant, .bus_mcu, .bus_asn,
    .bus_rnw, .bus_dsn, .addr_out, .bus_din, .regs_flat
);

`default_nettype wire

// ==== verif/mapper_tb.sv ====
// testbench for the memory mapper top
// memory model returns an address-derived word until written
// bus_grant and bus_busy are random
// cpu_cen pulses every fourth clk
`timescale 1ns/100ps
`default_nettype none

`include "mapper_params.svh"

module mapper_tb;
    import mapper_bus_pkg::*;
    import mapper_ctrl_pkg::*;

    localparam int TEST_CYCLES = 10 + 30 + 140 + 120 + 80 + 200;

    logic        clk = 1'b0;
    logic        rst;
    addr_t       cpu_addr, addr_out;
    word_t       cpu_dout, bus_dout, bus_din;
    logic [1:0]  cpu_dsn, bus_dsn;
    logic        cpu_rnw, cpu_asn, cpu_cen, edack_n, mcu_wr, bus_grant, bus_busy;
    fc_t         cpu_fc;
    reg_idx_t    mcu_addr;
    byte_t       mcu_dout, mcu_din;
    logic        cpu_rst, cpu_haltn, cpu_dtackn, bus_req, bus_mcu, bus_rnw, bus_asn;
    region_sel_t region_active;

    logic [1:0]  cen_div;
    word_t       mem [addr_t];
    byte_t       size_m [8];
    byte_t       base_m [8];
    int          model_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    mapper_top mapper_top_i (.*);

    always #4 clk = ~clk;

    // cpu_cen pulse every fourth cycle
    always @(posedge clk) begin
        #1;
        cen_div = cen_div + 2'd1;
        cpu_cen = (cen_div == 2'd0);
    end

    function automatic word_t mem_word(input addr_t a);
        if (mem.exists(a)) return mem[a];
        return a[16:1] ^ {a[23:17], a[23:15]};   // fill from whole address
    endfunction

    // memory and arbiter model
    always @(posedge clk) begin
        #1;
        if (bus_mcu && !bus_asn && !bus_rnw) mem[addr_out] = bus_din;
        bus_dout  = mem_word(addr_out);
        bus_grant = bus_req & ($urandom % 2 == 1);
        bus_busy  = ($urandom % 4 == 0);
    end

    function automatic region_sel_t expect_region(input addr_t a);
        region_sel_t sel;
        int nbits;
        sel = '0;
        for (int r = 7; r >= 0; r--) begin   // lower index overrides
            case (size_m[r][1:0])
                2'd0: nbits = 8;
                2'd1: nbits = 7;
                2'd2: nbits = 5;
                default: nbits = 3;
            endcase
            if ((a[23:16] >> (8 - nbits)) == (base_m[r] >> (8 - nbits)))
                sel = region_sel_t'(1) << r;
        end
        return sel;
    endfunction

    function automatic int total_errs();
        return model_errs + mapper_top_i.mapper_properties_i.fail_cnt;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            model_errs++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (total_errs() != errs_at_start) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    task automatic mcu_write(input reg_idx_t idx, input byte_t val);
        @(posedge clk);
        #1;
        mcu_addr = idx;
        mcu_dout = val;
        mcu_wr   = 1'b1;
        @(posedge clk);
        #1;
        mcu_wr = 1'b0;
    endtask

    task automatic mcu_read(input reg_idx_t idx, output byte_t val);
        @(posedge clk);
        #1;
        mcu_addr = idx;
        @(posedge clk);
        #1;
        val = mcu_din;
    endtask

    // word write on the low byte lane
    // top byte ff stays outside all regions
    task automatic cpu_write(input reg_idx_t idx, input byte_t val);
        @(posedge clk);
        #1;
        cpu_addr = {8'hff, 10'h0, idx};
        cpu_dout = {8'h00, val};
        cpu_rnw  = 1'b0;
        cpu_dsn  = 2'b10;
        cpu_asn  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        cpu_asn = 1'b1;
        cpu_rnw = 1'b1;
        cpu_dsn = 2'b11;
    endtask

    task automatic wait_xfer_done(input string name);
        int n;
        n = 0;
        while (mapper_top_i.xfer_busy && n < 200) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (mapper_top_i.xfer_busy) begin
            $display("%s: transfer did not finish in 200 cycles", name);
            model_errs++;
        end
    endtask

    initial begin
        int    errs;
        int    pulses;
        int    n;
        addr_t a;
        addr_t wa;
        word_t wd;
        byte_t hi;
        byte_t lo;

        void'($urandom(32'hf67cf052));
        rst = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_dsn = 2'b11;
        cpu_rnw = 1'b1;
        cpu_asn = 1'b1;
        cpu_fc = 3'd5;
        cpu_cen = 1'b0;
        cen_div = 2'd0;
        edack_n = 1'b1;
        mcu_addr = '0;
        mcu_dout = '0;
        mcu_wr = 1'b0;
        bus_grant = 1'b0;
        bus_busy = 1'b0;
        bus_dout = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        errs = total_errs();
        mcu_read(reg_idx_t'(`MAPPER_REG_IRQ), lo);
        compare_value("reset irq register", `MAPPER_IRQ_RESET, lo);
        compare_value("reset bus_asn", 1, bus_asn);
        compare_value("reset bus_req", 0, bus_req);
        compare_value("reset cpu_haltn", 1, cpu_haltn);
        finish_test("reset state", errs);

        errs = total_errs();
        cpu_write(5'd3, 8'h5a);
        mcu_read(5'd3, lo);
        compare_value("cpu write before lock", 8'h5a, lo);
        mcu_write(5'd6, 8'h11);                  // locks out the CPU
        cpu_write(5'd3, 8'ha5);
        mcu_read(5'd3, lo);
        compare_value("cpu write after lock", 8'h5a, lo);
        finish_test("write lockout", errs);

        errs = total_errs();
        for (int r = 0; r < 8; r++) begin
            size_m[r] = byte_t'($urandom);
            base_m[r] = byte_t'($urandom);
            mcu_write(reg_idx_t'(`MAPPER_REG_REGION + 2 * r), size_m[r]);
            mcu_write(reg_idx_t'(`MAPPER_REG_REGION + 2 * r + 1), base_m[r]);
        end
        for (int i = 0; i < 48; i++) begin
            a = addr_t'($urandom);
            n = $urandom % 8;
            if (i % 2 == 0) a[23:16] = base_m[n];   // aim at a region
            cpu_addr = a;
            cpu_fc = (i % 8 == 7) ? 3'd7 : 3'd5;
            #2;
            compare_value("region select", (cpu_fc == 3'd7) ? 0 : expect_region(a),
                          region_active);
            @(posedge clk);
            #1;
        end
        cpu_fc = 3'd5;
        finish_test("region decode", errs);

        errs = total_errs();
        for (int code = 0; code < 4; code++) begin
            mcu_write(reg_idx_t'(`MAPPER_REG_REGION), {4'h0, code[1:0], 2'b00});
            mcu_write(reg_idx_t'(`MAPPER_REG_REGION + 1), 8'h40);
            @(posedge clk);
            #1;
            cpu_addr = {8'h40, 15'($urandom)};
            cpu_rnw = 1'b1;
            cpu_asn = 1'b0;
            if (code == 3) begin
                repeat (6) begin
                    @(posedge clk);
                    #1;
                    edack_n = 1'($urandom);
                    #1;
                    compare_value("dtack from edack", edack_n, cpu_dtackn);
                end
            end else begin
                pulses = 0;
                n = 0;
                while (pulses < code + 1 && n < 20) begin
                    compare_value("dtack before pulse", 1, cpu_dtackn);
                    @(posedge clk);
                    if (cpu_cen) pulses++;
                    #1;
                    n++;
                end
                compare_value("dtack on pulse", 0, cpu_dtackn);
            end
            cpu_asn = 1'b1;
            edack_n = 1'b1;
            @(posedge clk);
            #1;
            compare_value("dtack release", 1, cpu_dtackn);
        end
        finish_test("dtack", errs);

        errs = total_errs();
        wa = addr_t'($urandom);
        wd = word_t'($urandom);
        mcu_write(reg_idx_t'(`MAPPER_REG_WRADDR), {1'b0, wa[23:17]});
        mcu_write(reg_idx_t'(`MAPPER_REG_WRADDR + 1), wa[16:9]);
        mcu_write(reg_idx_t'(`MAPPER_REG_WRADDR + 2), wa[8:1]);
        mcu_write(reg_idx_t'(`MAPPER_REG_DATA_HI), wd[15:8]);
        mcu_write(reg_idx_t'(`MAPPER_REG_DATA_LO), wd[7:0]);
        mcu_write(reg_idx_t'(`MAPPER_REG_XFER), 8'h01);
        wait_xfer_done("write transfer");
        compare_value("memory after write", wd, mem_word(wa));
        finish_test("write transfer", errs);

        errs = total_errs();
        for (int i = 0; i < 2; i++) begin
            a = (i == 0) ? addr_t'($urandom) : wa;
            mcu_write(reg_idx_t'(`MAPPER_REG_RDADDR), {1'b0, a[23:17]});
            mcu_write(reg_idx_t'(`MAPPER_REG_RDADDR + 1), a[16:9]);
            mcu_write(reg_idx_t'(`MAPPER_REG_RDADDR + 2), a[8:1]);
            mcu_write(reg_idx_t'(`MAPPER_REG_XFER), 8'h02);
            mcu_write(reg_idx_t'(`MAPPER_REG_XFER), 8'h01);   // dropped while busy
            wait_xfer_done("read transfer");
            repeat (3) begin
                @(posedge clk);
                #1;
                compare_value("second command ignored", 0, mapper_top_i.xfer_busy);
            end
            mcu_read(reg_idx_t'(`MAPPER_REG_DATA_HI), hi);
            mcu_read(reg_idx_t'(`MAPPER_REG_DATA_LO), lo);
            compare_value("read transfer data", mem_word(a), {hi, lo});
        end
        finish_test("read transfer", errs);

        $display("tests run %0d, failed %0d, model errors %0d, assertion failures %0d",
                 tests_run, tests_failed, model_errs,
                 mapper_top_i.mapper_properties_i.fail_cnt);
        if (total_errs() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog over a generous multiple of the run length
    initial begin
        #(20 * TEST_CYCLES * 8);
        $display("watchdog expired, tests did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
design/mapper_bus_pkg.sv
design/mapper_ctrl_pkg.sv
design/mapper_regs.sv
design/region_decode.sv
design/dtack_gen.sv
design/mcu_bus_master.sv
design/mapper_top.sv
verif/mapper_properties.sv
verif/mapper_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator and run, pass only if the pass line is printed
verilator --binary --timing --assert -f sim.f --top-module mapper_tb -o mapper_sim \
    && ./obj_dir/mapper_sim | tee /dev/stderr | grep -q "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
